// ==== alloc_top.f ====
+incdir+hw
+incdir+tb
hw/alloc_class_pkg.sv
hw/alloc_xfer_pkg.sv
hw/pipe_stage.sv
hw/size_classifier.sv
hw/free_decoder.sv
hw/slot_pool.sv
hw/alloc_top.sv
tb/alloc_tb.sv

// ==== tb/alloc_tb_model.svh ====
`ifndef ALLOC_TB_MODEL_SVH
`define ALLOC_TB_MODEL_SVH

// Freed slots in free order, tagged with their class
int   model_free_cls [$];
int   model_free_slot_q [$];
int   model_fresh [`ALLOC_CLASS_COUNT];
ptr_t model_last_ptr;

// Expected responses in request order
ptr_t exp_ptr_q [$];
logic exp_ok_q [$];

function automatic int model_block(input int cls);
  return 64 << cls;
endfunction

// Smallest block that holds the size, top class for anything larger
function automatic int model_classify(input req_size_t size);
  if (size <= 64) return 0;
  if (size <= 128) return 1;
  if (size <= 256) return 2;
  return 3;
endfunction

function automatic ptr_t model_pointer(input int cls, input int slot);
  return ptr_t'(cls * 16384 + slot * model_block(cls));
endfunction

function automatic int model_free_slot(input ptr_t ptr);
  return (int'(ptr) % 16384) / model_block(int'(ptr[15:14]));
endfunction

function automatic void model_reset();
  model_free_cls.delete();
  model_free_slot_q.delete();
  for (int c = 0; c < `ALLOC_CLASS_COUNT; c++) begin
    model_fresh[c] = 0;
  end
endfunction

function automatic void model_free(input ptr_t ptr);
  model_free_cls.push_back(int'(ptr[15:14]));
  model_free_slot_q.push_back(model_free_slot(ptr));
endfunction

function automatic void model_request(input req_size_t size);
  int   cls;
  int   slot;
  int   hit;
  logic ok;
  cls  = model_classify(size);
  slot = 0;
  hit  = -1;
  ok   = 1'b1;
  // Oldest freed slot of this class
  for (int i = model_free_cls.size() - 1; i >= 0; i--) begin
    if (model_free_cls[i] == cls) hit = i;
  end
  if (hit >= 0) begin
    slot = model_free_slot_q[hit];
    model_free_cls.delete(hit);
    model_free_slot_q.delete(hit);
  end else if (model_fresh[cls] < 16384 / model_block(cls)) begin
    slot = model_fresh[cls];
    model_fresh[cls]++;
  end else begin
    ok = 1'b0;
  end
  model_last_ptr = ok ? model_pointer(cls, slot) : ptr_t'(0);
  exp_ptr_q.push_back(model_last_ptr);
  exp_ok_q.push_back(ok);
endfunction

`endif

// ==== tb/alloc_tb.sv ====
`timescale 1ns/1ps
`include "alloc_config.svh"

module alloc_tb;

  import alloc_class_pkg::*;
  import alloc_xfer_pkg::*;

  // All five tests need under 1000 cycles
  localparam int MAX_CYCLES = 4000;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  req_size_t req_size;
  logic      req_ready;
  logic      alloc_valid;
  ptr_t      alloc_ptr;
  logic      alloc_ok;
  logic      alloc_ready;
  logic      free_valid;
  ptr_t      free_ptr;
  logic      free_ready;

  integer seed;
  logic   holdoff;
  int     cycle_count;
  int     check_count;
  int     error_count;
  int     test_start_errors;
  int     req_count;
  int     resp_count;
  string  test_name;
  ptr_t   resp_ptr;
  logic   resp_ok;
  ptr_t   exp_ptr;
  logic   exp_ok;
  ptr_t   freed_q [$];
  int     fresh_sizes [10] = '{0, 1, 64, 65, 128, 200, 256, 300, 512, 2000};

  `include "alloc_tb_model.svh"

  alloc_top i_alloc_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid   (req_valid),
    .req_size    (req_size),
    .req_ready   (req_ready),
    .alloc_valid (alloc_valid),
    .alloc_ptr   (alloc_ptr),
    .alloc_ok    (alloc_ok),
    .alloc_ready (alloc_ready),
    .free_valid  (free_valid),
    .free_ptr    (free_ptr),
    .free_ready  (free_ready)
  );

  always #50 clk = ~clk;

  // Random holdoff on the response path
  always @(negedge clk) begin
    alloc_ready = holdoff ? (($random(seed) & 1) == 1) : 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_alloc(input string name, input ptr_t exp_p, input logic exp_o,
                             input ptr_t act_p, input logic act_o);
    check_count++;
    if (act_p !== exp_p || act_o !== exp_o) begin
      $display("Mismatch in %s: expected ptr %h ok %b, actual ptr %h ok %b",
               name, exp_p, exp_o, act_p, act_o);
      error_count++;
    end
  endtask

  task automatic check_ready(input string name, input logic exp_r, input logic act_r);
    check_count++;
    if (act_r !== exp_r) begin
      $display("Mismatch in %s: expected free_ready %b, actual %b", name, exp_r, act_r);
      error_count++;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && alloc_valid && alloc_ready) begin
      resp_ptr = alloc_ptr;
      resp_ok  = alloc_ok;
      if (exp_ptr_q.size() == 0) begin
        $display("Error in %s: allocation response with no request outstanding", test_name);
        error_count++;
      end else begin
        exp_ptr = exp_ptr_q.pop_front();
        exp_ok  = exp_ok_q.pop_front();
        check_alloc(test_name, exp_ptr, exp_ok, resp_ptr, resp_ok);
      end
      resp_count++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks start and end on a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_request(input req_size_t size);
    req_valid = 1'b1;
    req_size  = size;
    @(posedge clk);
    while (!req_ready) @(posedge clk);
    model_request(size);
    req_count++;
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  task automatic send_free(input ptr_t ptr);
    free_valid = 1'b1;
    free_ptr   = ptr;
    @(posedge clk);
    while (!free_ready) @(posedge clk);
    model_free(ptr);
    @(negedge clk);
    free_valid = 1'b0;
  endtask

  task automatic wait_responses();
    while (resp_count < req_count) @(negedge clk);
  endtask

  task automatic allocate(input req_size_t size);
    send_request(size);
    wait_responses();
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Bounded wait for the free path to push back
  task automatic wait_free_stall(input int limit);
    int n;
    n = 0;
    while (free_ready && n < limit) begin
      @(negedge clk);
      n++;
    end
  endtask

  task automatic start_test(input string name);
    test_name         = name;
    test_start_errors = error_count;
  endtask

  task automatic end_test();
    $display("Test %s finished with %0d errors", test_name, error_count - test_start_errors);
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run stopped after %0d cycles in test %s", MAX_CYCLES, test_name);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    seed        = 32'h2255d6cb;
    clk         = 1'b0;
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    req_size    = '0;
    alloc_ready = 1'b1;
    free_valid  = 1'b0;
    free_ptr    = '0;
    holdoff     = 1'b0;
    check_count = 0;
    error_count = 0;
    req_count   = 0;
    resp_count  = 0;
    test_name   = "reset";
    model_reset();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    idle_cycles(1);
    check_ready(test_name, 1'b1, free_ready);

    start_test("fresh_classes");
    foreach (fresh_sizes[i]) allocate(req_size_t'(fresh_sizes[i]));
    end_test();

    start_test("reuse_order");
    send_free(model_pointer(1, 1));
    idle_cycles(3);
    send_free(model_pointer(1, 0));
    idle_cycles(3);
    send_free(model_pointer(2, 0));
    idle_cycles(3);
    allocate(100);
    allocate(100);
    allocate(100);
    allocate(250);
    end_test();

    start_test("class3_exhaust");
    while (model_fresh[3] < 32) allocate(400);
    allocate(400);
    check_alloc(test_name, '0, 1'b0, resp_ptr, resp_ok);
    send_free(model_pointer(3, 7));
    idle_cycles(3);
    allocate(400);
    check_alloc(test_name, model_pointer(3, 7), 1'b1, resp_ptr, resp_ok);
    end_test();

    start_test("ready_holdoff");
    holdoff = 1'b1;
    for (int i = 0; i < 40; i++) begin
      send_request(req_size_t'($random(seed) & 1023));
    end
    wait_responses();
    holdoff = 1'b0;
    end_test();

    start_test("free_backpressure");
    for (int i = 0; i < 20; i++) begin
      allocate(32);
      freed_q.push_back(model_last_ptr);
    end
    fork
      begin
        foreach (freed_q[i]) send_free(freed_q[i]);
      end
    join_none
    // Queue plus decoder buffer hold only 18 frees
    wait_free_stall(40);
    check_ready(test_name, 1'b0, free_ready);
    for (int i = 0; i < 20; i++) allocate(32);
    wait fork;
    idle_cycles(3);
    check_ready(test_name, 1'b1, free_ready);
    end_test();

    $display("Checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== hw/alloc_top.sv ====
`timescale 1ns/1ps

module alloc_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      req_valid,
  input  alloc_xfer_pkg::req_size_t req_size,
  output logic                      req_ready,
  output logic                      alloc_valid,
  output alloc_xfer_pkg::ptr_t      alloc_ptr,
  output logic                      alloc_ok,
  input  logic                      alloc_ready,
  input  logic                      free_valid,
  input  alloc_xfer_pkg::ptr_t      free_ptr,
  output logic                      free_ready
);

  import alloc_xfer_pkg::*;

  // Classifier to pool
  logic       cls_valid;
  class_req_t cls_req;
  logic       cls_ready;

  // Decoder to pool
  logic       fr_valid;
  free_slot_t fr_slot;
  logic       fr_ready;

  size_classifier i_size_classifier (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_size  (req_size),
    .req_ready (req_ready),
    .cls_valid (cls_valid),
    .cls_req   (cls_req),
    .cls_ready (cls_ready)
  );

  free_decoder i_free_decoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .free_valid (free_valid),
    .free_ptr   (free_ptr),
    .free_ready (free_ready),
    .fr_valid   (fr_valid),
    .fr_slot    (fr_slot),
    .fr_ready   (fr_ready)
  );

  slot_pool i_slot_pool (
    .clk         (clk),
    .rst_n       (rst_n),
    .cls_valid   (cls_valid),
    .cls_req     (cls_req),
    .cls_ready   (cls_ready),
    .fr_valid    (fr_valid),
    .fr_slot     (fr_slot),
    .fr_ready    (fr_ready),
    .alloc_valid (alloc_valid),
    .alloc_ptr   (alloc_ptr),
    .alloc_ok    (alloc_ok),
    .alloc_ready (alloc_ready)
  );

endmodule

// ==== hw/slot_pool.sv ====
`timescale 1ns/1ps
`include "alloc_config.svh"

module slot_pool (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cls_valid,
  input  alloc_xfer_pkg::class_req_t cls_req,
  output logic                       cls_ready,
  input  logic                       fr_valid,
  input  alloc_xfer_pkg::free_slot_t fr_slot,
  output logic                       fr_ready,
  output logic                       alloc_valid,
  output alloc_xfer_pkg::ptr_t       alloc_ptr,
  output logic                       alloc_ok,
  input  logic                       alloc_ready
);

  import alloc_class_pkg::*;
  import alloc_xfer_pkg::*;

  localparam int NCLS  = `ALLOC_CLASS_COUNT;
  localparam int DEPTH = `ALLOC_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  // Extra wrap bit tells full from empty
  typedef logic [AW:0] qptr_t;

  slot_idx_t       q_mem [NCLS][DEPTH];
  qptr_t           rd_ptr [NCLS];
  qptr_t           wr_ptr [NCLS];
  slot_cnt_t       fresh_cnt [NCLS];
  logic [NCLS-1:0] q_empty;
  logic [NCLS-1:0] q_full;

  logic      cls_fire;
  logic      fr_fire;
  logic      take_pop;
  logic      take_fresh;
  logic      pick_ok;
  slot_idx_t pick_slot;
  ptr_t      pick_ptr;

  ////////////////////////////////////////////////////////////////////////////
  // Recycle queue status
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < NCLS; c++) begin
      q_empty[c] = (rd_ptr[c] == wr_ptr[c]);
      q_full[c]  = (rd_ptr[c][AW] != wr_ptr[c][AW]) &&
                   (rd_ptr[c][AW-1:0] == wr_ptr[c][AW-1:0]);
    end
  end

  // Free stalls only on its own class
  assign fr_ready  = ~q_full[fr_slot.cls];
  assign fr_fire   = fr_valid & fr_ready;
  assign cls_ready = ~alloc_valid | alloc_ready;
  assign cls_fire  = cls_valid & cls_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Slot selection
  ////////////////////////////////////////////////////////////////////////////

  // Recycled slots first, then fresh ones in order
  always_comb begin
    take_pop   = 1'b0;
    take_fresh = 1'b0;
    pick_slot  = '0;
    if (!q_empty[cls_req.cls]) begin
      take_pop  = 1'b1;
      pick_slot = q_mem[cls_req.cls][rd_ptr[cls_req.cls][AW-1:0]];
    end else if (fresh_cnt[cls_req.cls] < class_slot_count(cls_req.cls)) begin
      take_fresh = 1'b1;
      pick_slot  = slot_idx_t'(fresh_cnt[cls_req.cls]);
    end
  end

  assign pick_ok = take_pop | take_fresh;

  // Region base plus slot times block size, zero when exhausted
  assign pick_ptr = pick_ok ?
                    ((ptr_t'(cls_req.cls) << `ALLOC_REGION_LOG2) |
                     (ptr_t'(pick_slot) << class_shift(cls_req.cls))) : '0;

  ////////////////////////////////////////////////////////////////////////////
  // State update
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (fr_fire) begin
      q_mem[fr_slot.cls][wr_ptr[fr_slot.cls][AW-1:0]] <= fr_slot.slot;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int c = 0; c < NCLS; c++) begin
        rd_ptr[c]    <= '0;
        wr_ptr[c]    <= '0;
        fresh_cnt[c] <= '0;
      end
      alloc_valid <= 1'b0;
    end else begin
      if (fr_fire) begin
        wr_ptr[fr_slot.cls] <= wr_ptr[fr_slot.cls] + 1'b1;
      end
      if (cls_fire && take_pop) begin
        rd_ptr[cls_req.cls] <= rd_ptr[cls_req.cls] + 1'b1;
      end
      if (cls_fire && take_fresh) begin
        fresh_cnt[cls_req.cls] <= fresh_cnt[cls_req.cls] + 1'b1;
      end
      // Response held until taken
      if (cls_fire) begin
        alloc_valid <= 1'b1;
      end else if (alloc_ready) begin
        alloc_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cls_fire) begin
      alloc_ptr <= pick_ptr;
      alloc_ok  <= pick_ok;
    end
  end

endmodule

// ==== hw/free_decoder.sv ====
`timescale 1ns/1ps
`include "alloc_config.svh"

module free_decoder (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       free_valid,
  input  alloc_xfer_pkg::ptr_t       free_ptr,
  output logic                       free_ready,
  output logic                       fr_valid,
  output alloc_xfer_pkg::free_slot_t fr_slot,
  input  logic                       fr_ready
);

  import alloc_class_pkg::*;
  import alloc_xfer_pkg::*;

  free_slot_t                    dec_slot;
  logic [`ALLOC_REGION_LOG2-1:0] region_off;

  assign region_off = free_ptr[`ALLOC_REGION_LOG2-1:0];

  // Region picks the class, offset over block size gives the slot
  always_comb begin
    dec_slot.cls  = free_ptr[`ALLOC_PTR_W-1 -: CLASS_W];
    dec_slot.slot = slot_idx_t'(region_off >> class_shift(dec_slot.cls));
  end

  pipe_stage #(
    .payload_t (free_slot_t)
  ) i_free_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (free_valid),
    .in_data   (dec_slot),
    .in_ready  (free_ready),
    .out_valid (fr_valid),
    .out_data  (fr_slot),
    .out_ready (fr_ready)
  );

endmodule

// ==== hw/size_classifier.sv ====
`timescale 1ns/1ps
`include "alloc_config.svh"

module size_classifier (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       req_valid,
  input  alloc_xfer_pkg::req_size_t  req_size,
  output logic                       req_ready,
  output logic                       cls_valid,
  output alloc_xfer_pkg::class_req_t cls_req,
  input  logic                       cls_ready
);

  import alloc_class_pkg::*;
  import alloc_xfer_pkg::*;

  class_req_t fit_req;

  // Smallest class that holds the size, anything larger lands in the top class
  always_comb begin
    fit_req.cls = class_id_t'(`ALLOC_CLASS_COUNT - 1);
    for (int c = `ALLOC_CLASS_COUNT - 1; c >= 0; c--) begin
      if (req_size <= (req_size_t'(1) << class_shift(class_id_t'(c)))) begin
        fit_req.cls = class_id_t'(c);
      end
    end
  end

  pipe_stage #(
    .payload_t (class_req_t)
  ) i_cls_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (req_valid),
    .in_data   (fit_req),
    .in_ready  (req_ready),
    .out_valid (cls_valid),
    .out_data  (cls_req),
    .out_ready (cls_ready)
  );

endmodule

// ==== hw/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  payload_t main_data;
  payload_t skid_data;
  logic     main_valid;
  logic     skid_valid;
  logic     in_fire;
  logic     main_free;

  // Ready comes straight off the skid flop
  assign in_ready  = ~skid_valid;
  assign out_valid = main_valid;
  assign out_data  = main_data;
  assign in_fire   = in_valid & in_ready;
  assign main_free = ~main_valid | out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      main_valid <= skid_valid | in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free && (skid_valid || in_fire)) begin
      main_data <= skid_valid ? skid_data : in_data;
    end
    // Output stalled, park the new beat
    if (!main_free && in_fire) begin
      skid_data <= in_data;
    end
  end

endmodule

// ==== hw/alloc_xfer_pkg.sv ====
`include "alloc_config.svh"

package alloc_xfer_pkg;

  import alloc_class_pkg::*;

  typedef logic [`ALLOC_PTR_W-1:0] ptr_t;

  // Requested size in bytes
  typedef logic [`ALLOC_SIZE_W-1:0] req_size_t;

  ////////////////////////////////////////////////////////////////////////////
  // Payloads into the pool
  ////////////////////////////////////////////////////////////////////////////

  // Classifier to pool
  typedef struct packed {
    class_id_t cls;
  } class_req_t;

  // Decoder to pool
  typedef struct packed {
    class_id_t cls;
    slot_idx_t slot;
  } free_slot_t;

endpackage

// ==== hw/alloc_class_pkg.sv ====
`include "alloc_config.svh"

package alloc_class_pkg;

  localparam int CLASS_W = $clog2(`ALLOC_CLASS_COUNT);
  localparam int SLOT_W = `ALLOC_REGION_LOG2 - `ALLOC_MIN_BLOCK_LOG2;

  // Class number doubles as the top pointer bits
  typedef logic [CLASS_W-1:0] class_id_t;

  // Sized for class 0, the smallest block
  typedef logic [SLOT_W-1:0] slot_idx_t;

  // One extra bit so a full region count fits
  typedef logic [SLOT_W:0] slot_cnt_t;

  // Block size log2, 6 for class 0 up to 9 for class 3
  function automatic int unsigned class_shift(class_id_t cls);
    return `ALLOC_MIN_BLOCK_LOG2 + int'(cls);
  endfunction

  // Slots per region: 256, 128, 64, 32
  function automatic slot_cnt_t class_slot_count(class_id_t cls);
    return slot_cnt_t'(1) << (`ALLOC_REGION_LOG2 - class_shift(cls));
  endfunction

endpackage

// ==== hw/alloc_config.svh ====
`ifndef ALLOC_CONFIG_SVH
`define ALLOC_CONFIG_SVH

// Pointer and request widths
`define ALLOC_PTR_W 16
`define ALLOC_SIZE_W 16

// Size classes, one per region
`define ALLOC_CLASS_COUNT 4

// Class 0 block is 64 bytes, each class doubles it
`define ALLOC_MIN_BLOCK_LOG2 6

// 16 KB per region
`define ALLOC_REGION_LOG2 14

// Recycle queue entries per class
`define ALLOC_FIFO_DEPTH 16

`endif
